/* ntm_erase_params.svh */
`ifndef NTM_ERASE_PARAMS_SVH
`define NTM_ERASE_PARAMS_SVH

// Fixed point format, UQ1.15 for weights and erase values
`define NTM_DATA_W 16
`define NTM_FRAC_W 15

// Memory row geometry
`define NTM_COLS 8
`define NTM_COL_W 3

// Buffering on both sides
`define NTM_IN_DEPTH 4
`define NTM_OUT_DEPTH 4

// Credits granted by the downstream receiver after reset
`define NTM_OUT_CREDITS 2

`endif

/* ntm_erase_pkg.sv */
`default_nettype none

`include "ntm_erase_params.svh"

package ntm_erase_pkg;

  // Entry kind on the input stream
  typedef enum logic {
    LOAD_ERASE = 1'b0,
    MEM_ELEM   = 1'b1
  } entry_kind_t;

  // Input stream entry, e for loads and m for memory elements
  typedef struct packed {
    entry_kind_t               kind;
    logic [`NTM_COL_W-1:0]     col;
    logic [`NTM_DATA_W-1:0]    weight;
    logic [`NTM_DATA_W-1:0]    data;
  } erase_in_t;

  // Erased word with its column tag
  typedef struct packed {
    logic [`NTM_COL_W-1:0]     col;
    logic [`NTM_DATA_W-1:0]    data;
  } erase_out_t;

  // Operation handed from issue to datapath
  typedef struct packed {
    logic [`NTM_COL_W-1:0]     col;
    logic [`NTM_DATA_W-1:0]    weight;
    logic [`NTM_DATA_W-1:0]    erase;
    logic [`NTM_DATA_W-1:0]    data;
  } erase_op_t;

endpackage

`default_nettype wire

/* ntm_credit_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module ntm_credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         push,
  input  payload_t                     push_data,
  input  logic                         pop,
  output payload_t                     pop_data,
  output logic                         empty,
  output logic [$clog2(DEPTH+1)-1:0]   count,
  output logic                         credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed on payload
  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_pop;

  // Pointer advance with wrap, works for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Head and status
  ////////////////////////////////////////////////////////////

  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];
  assign do_pop   = pop & ~empty;

  // One credit back per entry leaving
  assign credit   = do_pop;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves count alone
      case ({push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // Write port
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

/* ntm_erase_issue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_erase_issue (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   fifo_empty,
  input  ntm_erase_pkg::erase_in_t               head,
  output logic                                   fifo_pop,
  input  logic [$clog2(`NTM_OUT_DEPTH+1)-1:0]    out_count,
  output logic                                   op_valid,
  output ntm_erase_pkg::erase_op_t               op
);

  import ntm_erase_pkg::*;

  localparam int CNT_W = $clog2(`NTM_OUT_DEPTH + 1);

  // Erase vector e(k)
  logic [`NTM_DATA_W-1:0] erase_store [`NTM_COLS];

  // Issues one and two cycles back, i.e. datapath occupancy
  logic [1:0]             issued_q;
  logic [CNT_W:0]         reserved;
  logic                   room;
  logic                   is_load;

  ////////////////////////////////////////////////////////////
  // Pop decision
  ////////////////////////////////////////////////////////////

  assign is_load  = (head.kind == LOAD_ERASE);

  // Output FIFO words plus words still in the pipe
  assign reserved = {1'b0, out_count}
                  + (CNT_W+1)'(issued_q[0])
                  + (CNT_W+1)'(issued_q[1]);
  assign room     = (reserved < (CNT_W+1)'(`NTM_OUT_DEPTH));

  // Loads always go, memory elements need a reserved slot
  assign fifo_pop = ~fifo_empty & (is_load | room);
  assign op_valid = fifo_pop & ~is_load;

  // Lookup by column
  assign op.col    = head.col;
  assign op.weight = head.weight;
  assign op.erase  = erase_store[head.col];
  assign op.data   = head.data;

  ////////////////////////////////////////////////////////////
  // Erase store and in-flight tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // Zero erase means factor 1.0
      for (int k = 0; k < `NTM_COLS; k++) begin
        erase_store[k] <= '0;
      end
      issued_q <= '0;
    end else begin
      if (fifo_pop && is_load) begin
        erase_store[head.col] <= head.data;
      end
      issued_q <= {issued_q[0], op_valid};
    end
  end

endmodule

`default_nettype wire

/* ntm_erase_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_erase_datapath (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        op_valid,
  input  ntm_erase_pkg::erase_op_t    op,
  output logic                        res_valid,
  output ntm_erase_pkg::erase_out_t   res
);

  localparam int DW = `NTM_DATA_W;
  localparam int FW = `NTM_FRAC_W;

  // 1.0 in UQ1.15
  localparam logic [DW-1:0] UNITY = DW'(1 << FW);

  logic [DW-1:0]            w_clamp;
  logic [DW-1:0]            e_clamp;
  logic [2*DW-1:0]          we_prod;
  logic [DW-1:0]            factor;
  logic [2*DW-1:0]          mf_prod;

  // Stage 1 registers
  logic                     s1_valid;
  logic [DW-1:0]            s1_factor;
  logic [DW-1:0]            s1_data;
  logic [`NTM_COL_W-1:0]    s1_col;

  // Saturate anything above 1.0
  function automatic logic [DW-1:0] clamp(input logic [DW-1:0] x);
    return (x > UNITY) ? UNITY : x;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1, erase factor 1 - w*e
  ////////////////////////////////////////////////////////////

  assign w_clamp = clamp(op.weight);
  assign e_clamp = clamp(op.erase);
  assign we_prod = (2*DW)'(w_clamp) * (2*DW)'(e_clamp);
  // Truncating shift, product is at most 1.0
  assign factor  = UNITY - we_prod[FW +: DW];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_factor <= factor;
    s1_data   <= op.data;
    s1_col    <= op.col;
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, scaled memory word
  ////////////////////////////////////////////////////////////

  // m * f fits in 31 bits
  assign mf_prod = (2*DW)'(s1_data) * (2*DW)'(s1_factor);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    res.data <= mf_prod[FW +: DW];
    res.col  <= s1_col;
  end

endmodule

`default_nettype wire

/* ntm_credit_sender.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_credit_sender (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        fifo_empty,
  input  ntm_erase_pkg::erase_out_t   head,
  output logic                        fifo_pop,
  input  logic                        out_credit,
  output logic                        out_valid,
  output ntm_erase_pkg::erase_out_t   out_word
);

  localparam int CRED_W = $clog2(`NTM_OUT_CREDITS + 1);

  // Credits currently held toward the receiver
  logic [CRED_W-1:0] credit_cnt;

  ////////////////////////////////////////////////////////////
  // Send path
  ////////////////////////////////////////////////////////////

  // Send only with a word ready and a credit in hand
  assign fifo_pop  = ~fifo_empty & (credit_cnt != '0);
  assign out_valid = fifo_pop;
  assign out_word  = head;

  ////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credit_cnt <= CRED_W'(`NTM_OUT_CREDITS);
    end else begin
      // Return and spend in one cycle cancel out
      case ({out_credit, fifo_pop})
        2'b10:   credit_cnt <= credit_cnt + CRED_W'(1);
        2'b01:   credit_cnt <= credit_cnt - CRED_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* ntm_erasing.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_erasing (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        in_valid,
  input  ntm_erase_pkg::erase_in_t    in_entry,
  output logic                        in_credit,
  output logic                        out_valid,
  output ntm_erase_pkg::erase_out_t   out_word,
  input  logic                        out_credit
);

  import ntm_erase_pkg::*;

  // Input side
  erase_in_t                                  in_head;
  logic                                       in_empty;
  logic                                       in_pop;

  // Processing
  logic                                       op_valid;
  erase_op_t                                  op;
  logic                                       res_valid;
  erase_out_t                                 res;

  // Output side
  erase_out_t                                 out_head;
  logic                                       out_empty;
  logic                                       out_pop;
  logic [$clog2(`NTM_OUT_DEPTH+1)-1:0]        out_count;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  // Upstream credits equal this depth
  ntm_credit_fifo #(
    .payload_t (erase_in_t),
    .DEPTH     (`NTM_IN_DEPTH)
  ) in_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (in_valid),
    .push_data (in_entry),
    .pop       (in_pop),
    .pop_data  (in_head),
    .empty     (in_empty),
    .count     (),
    .credit    (in_credit)
  );

  ////////////////////////////////////////////////////////////
  // Processing
  ////////////////////////////////////////////////////////////

  ntm_erase_issue issue (
    .CLK        (CLK),
    .RST        (RST),
    .fifo_empty (in_empty),
    .head       (in_head),
    .fifo_pop   (in_pop),
    .out_count  (out_count),
    .op_valid   (op_valid),
    .op         (op)
  );

  ntm_erase_datapath datapath (
    .CLK       (CLK),
    .RST       (RST),
    .op_valid  (op_valid),
    .op        (op),
    .res_valid (res_valid),
    .res       (res)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  // Room is reserved at issue, so no overflow here
  ntm_credit_fifo #(
    .payload_t (erase_out_t),
    .DEPTH     (`NTM_OUT_DEPTH)
  ) out_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (res_valid),
    .push_data (res),
    .pop       (out_pop),
    .pop_data  (out_head),
    .empty     (out_empty),
    .count     (out_count),
    .credit    ()
  );

  ntm_credit_sender sender (
    .CLK        (CLK),
    .RST        (RST),
    .fifo_empty (out_empty),
    .head       (out_head),
    .fifo_pop   (out_pop),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_word   (out_word)
  );

endmodule

`default_nettype wire

/* ntm_erasing_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_erasing_asserts (
  input logic                                   CLK,
  input logic                                   RST,
  input logic                                   out_valid,
  input logic [$clog2(`NTM_OUT_CREDITS+1)-1:0]  credit_cnt,
  input logic [$clog2(`NTM_IN_DEPTH+1)-1:0]     in_count,
  input logic                                   op_valid,
  input logic                                   res_valid,
  input logic                                   out_credit
);

  localparam int IN_CW  = $clog2(`NTM_IN_DEPTH + 1);
  localparam int CRED_W = $clog2(`NTM_OUT_CREDITS + 1);
  localparam logic [IN_CW-1:0] IN_MAX = IN_CW'(`NTM_IN_DEPTH);

  // Credits held as seen on the output pins
  logic [CRED_W-1:0] pin_credits;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pin_credits <= CRED_W'(`NTM_OUT_CREDITS);
    end else begin
      pin_credits <= pin_credits + CRED_W'(out_credit) - CRED_W'(out_valid);
    end
  end

  // A word goes out only against a held credit
  a_send_with_credit: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> (pin_credits != '0))
    else $error("out_valid asserted with no output credit held");

  // Sender counter agrees with the pin level count
  a_credit_track: assert property (@(posedge CLK) disable iff (RST)
    credit_cnt == pin_credits)
    else $error("Sender credit counter differs from credits seen on the pins");

  // Upstream credits bound the input FIFO fill
  a_in_fifo_bound: assert property (@(posedge CLK) disable iff (RST)
    in_count <= IN_MAX)
    else $error("Input FIFO count above its depth");

  // Fixed two cycle datapath, both directions
  a_latency_fwd: assert property (@(posedge CLK) disable iff (RST)
    op_valid |-> ##2 res_valid)
    else $error("res_valid missing two cycles after op_valid");
  a_latency_back: assert property (@(posedge CLK) disable iff (RST)
    res_valid |-> $past(op_valid, 2))
    else $error("res_valid without op_valid two cycles before");

endmodule

`default_nettype wire

/* ntm_erasing_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ntm_erase_params.svh"

module ntm_erasing_tb;

  import ntm_erase_pkg::*;

  localparam int DW           = `NTM_DATA_W;
  localparam int CW           = `NTM_COL_W;
  localparam int NUM_PLAIN    = 24;
  localparam int NUM_DIRECTED = 5;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_ENTRIES  = NUM_PLAIN + NUM_DIRECTED + NUM_RANDOM;
  localparam int RESET_CYCLES = 16;
  // 1.0 in UQ1.15
  localparam logic [DW-1:0] UNITY = DW'(1 << `NTM_FRAC_W);

  logic       CLK;
  logic       RST;
  logic       in_valid;
  erase_in_t  in_entry;
  logic       in_credit;
  logic       out_valid;
  erase_out_t out_word;
  logic       out_credit;

  // Reference erase vector and expected words in order
  logic [DW-1:0] model_store [`NTM_COLS];
  erase_out_t    expected_q [$];

  int errors               = 0;
  int sent                 = 0;
  int words_expected       = 0;
  int words_seen           = 0;
  int in_credits_seen      = 0;
  int out_credits_returned = 0;
  int credits_owed         = 0;

  ntm_erasing dut (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_entry   (in_entry),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_credit (out_credit)
  );

  bind ntm_erasing ntm_erasing_asserts asserts (
    .CLK        (CLK),
    .RST        (RST),
    .out_valid  (out_valid),
    .credit_cnt (sender.credit_cnt),
    .in_count   (in_fifo.count),
    .op_valid   (op_valid),
    .res_valid  (res_valid),
    .out_credit (out_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Reference arithmetic
  ////////////////////////////////////////////////////////////

  function automatic logic [DW-1:0] clamp_unity(input logic [DW-1:0] x);
    return (x > UNITY) ? UNITY : x;
  endfunction

  // m * (1 - w*e), both products truncated
  function automatic logic [DW-1:0] erased_word(input logic [DW-1:0] m,
                                                input logic [DW-1:0] w,
                                                input logic [DW-1:0] e);
    logic [63:0] p;
    logic [63:0] f;
    logic [63:0] r;
    p = (64'(clamp_unity(w)) * 64'(clamp_unity(e))) >> `NTM_FRAC_W;
    f = 64'(UNITY) - p;
    r = (64'(m) * f) >> `NTM_FRAC_W;
    return r[DW-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Mostly in range, with exact 1.0, zero and above 1.0
  function automatic logic [DW-1:0] fraction_value();
    int unsigned pick;
    pick = $urandom % 16;
    if (pick == 0) return UNITY;
    if (pick == 1) return DW'(32'd32769 + ($urandom % 32767));
    if (pick == 2) return '0;
    return DW'($urandom % 32769);
  endfunction

  function automatic erase_in_t make_entry(input entry_kind_t kind, input int col,
                                           input logic [DW-1:0] weight,
                                           input logic [DW-1:0] data);
    erase_in_t entry;
    entry.kind   = kind;
    entry.col    = CW'(col);
    entry.weight = weight;
    entry.data   = data;
    return entry;
  endfunction

  // About one load in four when loads are allowed
  function automatic erase_in_t random_entry(input bit allow_load);
    erase_in_t entry;
    entry.kind   = (allow_load && ($urandom % 4 == 0)) ? LOAD_ERASE : MEM_ELEM;
    entry.col    = CW'($urandom % `NTM_COLS);
    entry.weight = fraction_value();
    entry.data   = (entry.kind == LOAD_ERASE) ? fraction_value() : DW'($urandom);
    return entry;
  endfunction

  task automatic update_model(input erase_in_t entry);
    erase_out_t exp_word;
    if (entry.kind == LOAD_ERASE) begin
      model_store[entry.col] = entry.data;
    end else begin
      exp_word.col  = entry.col;
      exp_word.data = erased_word(entry.data, entry.weight, model_store[entry.col]);
      expected_q.push_back(exp_word);
      words_expected++;
    end
  endtask

  // Drive one entry on a falling edge, holding off until a credit is free
  task automatic send_entry(input erase_in_t entry);
    @(negedge CLK);
    while (sent - in_credits_seen >= `NTM_IN_DEPTH) begin
      in_valid = 1'b0;
      @(negedge CLK);
    end
    in_valid = 1'b1;
    in_entry = entry;
    sent++;
    update_model(entry);
  endtask

  task automatic idle_cycle();
    @(negedge CLK);
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp_val);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Outputs depend only on DUT state, sampled on the rising edge
  always @(posedge CLK) begin : monitor
    erase_out_t head;
    if (!RST) begin
      if (out_valid) begin
        words_seen++;
        if (words_seen > out_credits_returned + `NTM_OUT_CREDITS)
          report_failure("output word sent beyond the credits granted");
        if (expected_q.size() == 0) begin
          report_failure("output word arrived with no memory element pending");
        end else begin
          head = expected_q.pop_front();
          check_value("out_word.col", 32'(out_word.col), 32'(head.col));
          check_value("out_word.data", 32'(out_word.data), 32'(head.data));
        end
        credits_owed++;
      end
      if (out_credit) out_credits_returned++;
      if (in_credit) begin
        if (in_credits_seen >= sent)
          report_failure("in_credit pulsed with no entry outstanding");
        in_credits_seen++;
      end
    end
  end

  // Sink with random gaps and long stalls
  initial begin : sink
    int stall;
    stall      = 0;
    out_credit = 1'b0;
    forever begin
      @(negedge CLK);
      out_credit = 1'b0;
      if (stall > 0) begin
        stall--;
      end else if ($urandom % 128 == 0) begin
        stall = 20 + int'($urandom % 100);
      end else if (credits_owed > 0 && ($urandom % 2 == 0)) begin
        out_credit = 1'b1;
        credits_owed--;
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_ENTRIES * 40 + RESET_CYCLES) @(posedge CLK);
    $display("Timeout: %0d of %0d words seen, run did not drain", words_seen, words_expected);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    void'($urandom(32'h5d2b6e5b));
    RST        = 1'b1;
    in_valid   = 1'b0;
    in_entry   = '0;
    for (int k = 0; k < `NTM_COLS; k++) model_store[k] = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Zero erase store, words pass unchanged
    for (int i = 0; i < NUM_PLAIN; i++) send_entry(random_entry(1'b0));

    // Full erase and clamped operands
    send_entry(make_entry(LOAD_ERASE, 2, '0, UNITY));
    send_entry(make_entry(MEM_ELEM, 2, UNITY, 16'hbeef));
    send_entry(make_entry(LOAD_ERASE, 5, '0, 16'hffff));
    send_entry(make_entry(MEM_ELEM, 5, 16'hc000, 16'h1234));
    send_entry(make_entry(MEM_ELEM, 5, 16'h4000, 16'h8000));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if ($urandom % 8 == 0) idle_cycle();
      send_entry(random_entry(1'b1));
    end
    idle_cycle();

    wait (words_seen == words_expected && in_credits_seen == sent);
    repeat (20) @(posedge CLK);
    check_value("in_credit total", 32'(in_credits_seen), 32'(sent));
    check_value("out_valid total", 32'(words_seen), 32'(words_expected));
    if (expected_q.size() != 0) report_failure("expected words left undelivered");

    $display("Closing: %0d entries sent, %0d words checked, %0d errors",
             sent, words_seen, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
ntm_erase_pkg.sv
ntm_credit_fifo.sv
ntm_erase_issue.sv
ntm_erase_datapath.sv
ntm_credit_sender.sv
ntm_erasing.sv
ntm_erasing_asserts.sv
ntm_erasing_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ntm_erasing_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := TESTS FAILED
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
